// File: logic/stepper_macros.svh
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// Angle input and scale factor, both Q16.16
`define ANGLE_W 32
`define FRAC_W 16

// Step count width, products beyond this are rejected
`define STEP_W 24

// Microsteps per angle unit in Q16.16 (1.5)
`define STEP_SCALE 32'h0001_8000

// clk_i cycles per profiler tick
`define TICK_CYCLES 4

// Rate level, ceiling reached at cruise
`define RATE_W 4
`define RATE_MAX 8

// Step period = BASE_PERIOD - rate * RATE_GAIN
`define BASE_PERIOD 40
`define RATE_GAIN 4

`endif

// File: logic/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  `include "stepper_macros.svh"

  // Stage 1 to stage 2, valid is a single-cycle strobe
  typedef struct packed {
    logic               valid;
    logic               dir;
    logic [`STEP_W-1:0] steps;
  } move_cmd_t;

  // Stage 2 to stage 3, held as levels for the whole move
  typedef struct packed {
    logic               active;
    logic               dir;
    logic [`RATE_W-1:0] rate;
  } rate_cmd_t;

  // Ramp profiler FSM
  typedef enum logic [2:0] {
    RAMP_IDLE,
    RAMP_ACCEL,
    RAMP_CRUISE,
    RAMP_DECEL,
    RAMP_DONE
  } ramp_state_e;

endpackage

`default_nettype wire

// File: logic/angle_scaler.sv
`timescale 1ns/10ps
`default_nettype none

`include "stepper_macros.svh"

module angle_scaler (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic                  dir_i,
  input  logic [`ANGLE_W-1:0]   angle_i,
  input  logic                  busy_i,
  output stepper_pkg::move_cmd_t cmd_o,
  output logic                  err_o
);

  import stepper_pkg::*;

  // Q16.16 times Q16.16 gives Q32.32
  localparam int PROD_W  = 2 * `ANGLE_W;
  localparam int INT_LSB = 2 * `FRAC_W;

  logic [PROD_W-1:0]  product;
  logic [`STEP_W-1:0] int_steps;
  logic               overflow;
  logic               accept;
  move_cmd_t          next_cmd;

  assign product   = PROD_W'(angle_i) * PROD_W'(`STEP_SCALE);
  assign int_steps = product[INT_LSB +: `STEP_W];
  // Any integer bit above the step width is lost motion
  assign overflow  = |product[PROD_W-1:INT_LSB+`STEP_W];

  // A command still in flight to stage 2 counts as busy too
  assign accept = start_i && !busy_i && !cmd_o.valid;

  always_comb begin
    next_cmd.valid = !overflow;
    next_cmd.dir   = dir_i;
    next_cmd.steps = int_steps;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_o <= '0;
      err_o <= 1'b0;
    end else begin
      cmd_o.valid <= 1'b0;
      if (accept) begin
        cmd_o <= next_cmd;
        // Error stays up until the next accepted start
        err_o <= overflow;
      end
    end
  end

  a_no_cmd_with_err: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(cmd_o.valid && err_o)
  ) else $error("move command issued while error is set");

endmodule

`default_nettype wire

// File: logic/ramp_profiler.sv
`timescale 1ns/10ps
`default_nettype none

`include "stepper_macros.svh"

module ramp_profiler (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  stepper_pkg::move_cmd_t cmd_i,
  input  logic                   step_done_i,
  output stepper_pkg::rate_cmd_t rate_o,
  output logic                   busy_o,
  output logic                   done_o
);

  import stepper_pkg::*;

  localparam int TICK_W = $clog2(`TICK_CYCLES + 1);

  ramp_state_e        state_q;
  logic [TICK_W-1:0]  tick_cnt_q;
  logic               tick;
  logic [`RATE_W-1:0] rate_q;
  logic               dir_q;
  logic [`STEP_W-1:0] remain_q;
  logic [`STEP_W-1:0] spent_q;
  logic [`STEP_W-1:0] ramp_len_q;
  logic [`STEP_W-1:0] accel_steps;
  logic               last_step;

  // Timekeeping tick, one cycle in TICK_CYCLES
  assign tick = (tick_cnt_q == TICK_W'(`TICK_CYCLES - 1));

  // While still accelerating, everything spent so far belongs to the ramp
  assign accel_steps = (state_q == RAMP_ACCEL) ? spent_q : ramp_len_q;
  assign last_step   = step_done_i && (remain_q == `STEP_W'(1));

  assign busy_o = (state_q == RAMP_ACCEL) || (state_q == RAMP_CRUISE) ||
                  (state_q == RAMP_DECEL);
  assign done_o = (state_q == RAMP_DONE);

  always_comb begin
    rate_o.active = busy_o;
    rate_o.dir    = dir_q;
    rate_o.rate   = rate_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= RAMP_IDLE;
      tick_cnt_q <= '0;
      rate_q     <= '0;
      dir_q      <= 1'b0;
      remain_q   <= '0;
      spent_q    <= '0;
      ramp_len_q <= '0;
    end else begin
      case (state_q)
        RAMP_IDLE: begin
          if (cmd_i.valid) begin
            remain_q   <= cmd_i.steps;
            dir_q      <= cmd_i.dir;
            spent_q    <= '0;
            ramp_len_q <= '0;
            tick_cnt_q <= '0;
            rate_q     <= `RATE_W'(1);
            // Nothing to move, report completion at once
            state_q    <= (cmd_i.steps == '0) ? RAMP_DONE : RAMP_ACCEL;
          end
        end

        RAMP_ACCEL, RAMP_CRUISE, RAMP_DECEL: begin
          tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;

          if (step_done_i) begin
            remain_q <= remain_q - 1'b1;
            spent_q  <= spent_q + 1'b1;
          end

          if (last_step) begin
            state_q <= RAMP_DONE;
          end else if (state_q != RAMP_DECEL && remain_q <= accel_steps) begin
            // Enough distance left only to brake over the same steps
            state_q <= RAMP_DECEL;
          end else if (state_q == RAMP_ACCEL && tick &&
                       rate_q == `RATE_W'(`RATE_MAX - 1)) begin
            state_q    <= RAMP_CRUISE;
            ramp_len_q <= spent_q;
          end

          if (tick) begin
            if (state_q == RAMP_ACCEL && rate_q < `RATE_W'(`RATE_MAX)) begin
              rate_q <= rate_q + 1'b1;
            end else if (state_q == RAMP_DECEL && rate_q > `RATE_W'(1)) begin
              rate_q <= rate_q - 1'b1;
            end
          end
        end

        RAMP_DONE: state_q <= RAMP_IDLE;

        default: state_q <= RAMP_IDLE;
      endcase
    end
  end

  a_rate_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rate_o.active |-> (rate_o.rate >= `RATE_W'(1) && rate_o.rate <= `RATE_W'(`RATE_MAX))
  ) else $error("rate level out of range during move");

  a_done_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o
  ) else $error("done pulse longer than one cycle");

endmodule

`default_nettype wire

// File: logic/step_pulse_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "stepper_macros.svh"

module step_pulse_gen (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  stepper_pkg::rate_cmd_t rate_i,
  output logic                   step_o,
  output logic                   dir_o,
  output logic                   step_done_o
);

  import stepper_pkg::*;

  localparam int PERIOD_W = $clog2(`BASE_PERIOD + 1);

  logic [PERIOD_W-1:0] rate_cut;
  logic [PERIOD_W-1:0] period;
  logic [PERIOD_W-1:0] cnt_q;
  logic [PERIOD_W-1:0] cnt_next;
  logic                step_q;

  // Higher rate shortens the period by RATE_GAIN cycles per level
  assign rate_cut = PERIOD_W'(rate_i.rate) * PERIOD_W'(`RATE_GAIN);
  assign period   = PERIOD_W'(`BASE_PERIOD) - rate_cut;
  assign cnt_next = cnt_q + 1'b1;

  // Counter runs only during a move and restarts when the move ends
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      step_q <= 1'b0;
    end else if (!rate_i.active) begin
      cnt_q  <= '0;
      step_q <= 1'b0;
    end else if (cnt_next >= period) begin
      // Period may shrink under the count while the rate rises
      cnt_q  <= '0;
      step_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_next;
      step_q <= 1'b0;
    end
  end

  assign step_o      = step_q;
  assign step_done_o = step_q;

  // Direction held steady for the whole move
  assign dir_o = rate_i.active && rate_i.dir;

  a_step_needs_active: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    step_o |-> rate_i.active
  ) else $error("step pulse outside an active move");

endmodule

`default_nettype wire

// File: logic/stepper_drive_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "stepper_macros.svh"

module stepper_drive_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                dir_i,
  input  logic [`ANGLE_W-1:0] angle_i,
  output logic                step_o,
  output logic                dir_o,
  output logic                busy_o,
  output logic                done_o,
  output logic                err_o
);

  import stepper_pkg::*;

  move_cmd_t move_cmd;
  rate_cmd_t rate_cmd;
  logic      step_done;

  // Stage 1, angle to step count
  angle_scaler i_angle_scaler (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .dir_i   (dir_i),
    .angle_i (angle_i),
    .busy_i  (busy_o),
    .cmd_o   (move_cmd),
    .err_o   (err_o)
  );

  // Stage 2, trapezoidal rate profile
  ramp_profiler i_ramp_profiler (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (move_cmd),
    .step_done_i (step_done),
    .rate_o      (rate_cmd),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // Stage 3, step pulses and direction
  step_pulse_gen i_step_pulse_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rate_i      (rate_cmd),
    .step_o      (step_o),
    .dir_o       (dir_o),
    .step_done_o (step_done)
  );

endmodule

`default_nettype wire

// File: tests/stepper_drive_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "stepper_macros.svh"

module stepper_drive_tb;

  localparam int unsigned SEED = 32'hfab3_8221;
  // About 240 steps over all tests at up to 36 cycles each, doubled, plus resets
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam int FAST_PERIOD = `BASE_PERIOD - `RATE_MAX * `RATE_GAIN;
  localparam int SLOW_PERIOD = `BASE_PERIOD - `RATE_GAIN;

  logic                clk_i;
  logic                rst_n_i;
  logic                start_i;
  logic                dir_i;
  logic [`ANGLE_W-1:0] angle_i;
  logic                step_o;
  logic                dir_o;
  logic                busy_o;
  logic                done_o;
  logic                err_o;

  int unsigned cycle_cnt = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          step_cnt = 0;
  int          done_cnt = 0;
  int          last_step_cyc = 0;
  int          done_cyc = 0;
  int          intervals[$];
  logic        exp_dir = 1'b0;

  stepper_drive_top i_dut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .dir_i   (dir_i),
    .angle_i (angle_i),
    .step_o  (step_o),
    .dir_o   (dir_o),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .err_o   (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  function automatic void check_cond(input bit ok, input string msg);
    check_cnt++;
    assert (ok) else begin
      err_cnt++;
      $display("FAIL @ %0d ns: %s", $time, msg);
    end
  endfunction

  // Integer part of angle times 1.5, angle in Q16.16
  function automatic longint scaled_steps(input logic [`ANGLE_W-1:0] angle);
    return (longint'(angle) * 3) >> 17;
  endfunction

  // Pulse monitor, samples the outputs of the cycle that just ended
  always @(posedge clk_i) begin
    if (step_o) begin
      check_cond(dir_o === exp_dir, "dir_o differs from commanded direction during a step");
      if (step_cnt > 0) begin
        intervals.push_back(cycle_cnt - last_step_cyc);
      end
      last_step_cyc = cycle_cnt;
      step_cnt++;
    end
    if (done_o) begin
      done_cnt++;
      done_cyc = cycle_cnt;
    end
  end

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    start_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_cond({step_o, dir_o, busy_o, done_o, err_o} === 5'b0, "outputs not low after reset");
  endtask

  task automatic run_move(input logic [`ANGLE_W-1:0] angle, input logic dir,
                          input bit second_start);
    longint exp_steps;
    exp_steps = scaled_steps(angle);
    @(negedge clk_i);
    step_cnt = 0;
    done_cnt = 0;
    intervals.delete();
    exp_dir = dir;
    @(posedge clk_i);
    start_i <= 1'b1;
    dir_i   <= dir;
    angle_i <= angle;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
    check_cond(!busy_o, "busy_o high one cycle after start");
    @(negedge clk_i);
    check_cond(busy_o == (exp_steps > 0), "busy_o wrong two cycles after start");
    if (second_start) begin
      // Other angle and direction, the running move must not see it
      @(posedge clk_i);
      start_i <= 1'b1;
      dir_i   <= !dir;
      angle_i <= angle << 1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
    end
    while (!done_o && !err_o) begin
      check_cond(busy_o, "busy_o dropped before done_o");
      @(negedge clk_i);
    end
    check_cond(done_o && !err_o, "move ended with err_o instead of done_o");
    check_cond(!busy_o, "busy_o still high in the done_o cycle");
    @(negedge clk_i);
    check_cond(!done_o, "done_o longer than one cycle");
    check_cond(step_cnt == exp_steps,
               $sformatf("step count %0d, expected %0d", step_cnt, exp_steps));
    check_cond(done_cnt == 1, $sformatf("done_o pulsed %0d times", done_cnt));
    foreach (intervals[i]) begin
      check_cond(intervals[i] >= FAST_PERIOD && intervals[i] <= SLOW_PERIOD,
                 $sformatf("step interval %0d out of range", intervals[i]));
    end
    if (exp_steps > 0) begin
      check_cond(done_cyc - last_step_cyc inside {[1:2]},
                 $sformatf("done_o %0d cycles after last step", done_cyc - last_step_cyc));
    end
  endtask

  // Intervals fall to the fastest one and then only grow
  task automatic check_ramp_shape();
    int min_idx;
    min_idx = 0;
    check_cond(intervals.size() > 0, "no step intervals recorded");
    if (intervals.size() > 0) begin
      foreach (intervals[i]) begin
        if (intervals[i] < intervals[min_idx]) begin
          min_idx = i;
        end
      end
      check_cond(intervals[min_idx] == FAST_PERIOD,
                 $sformatf("fastest interval %0d, expected %0d", intervals[min_idx], FAST_PERIOD));
      for (int i = 1; i <= min_idx; i++) begin
        check_cond(intervals[i] <= intervals[i-1], $sformatf("interval rises at step %0d", i));
      end
      for (int i = min_idx + 1; i < intervals.size(); i++) begin
        check_cond(intervals[i] >= intervals[i-1], $sformatf("interval falls at step %0d", i));
      end
    end
  endtask

  task automatic check_largest_angle();
    logic [`ANGLE_W-1:0] angle;
    bit                  exp_err;
    angle = '1;
    // A 1.5 scale keeps the whole Q16.16 range under the step width
    exp_err = scaled_steps(angle) >= (longint'(1) << `STEP_W);
    @(posedge clk_i);
    start_i <= 1'b1;
    angle_i <= angle;
    @(posedge clk_i);
    start_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    check_cond(err_o == exp_err, "err_o wrong for the largest angle");
    check_cond(busy_o == !exp_err, "busy_o wrong for the largest angle");
    // Abort the very long move
    apply_reset();
  endtask

  initial begin
    logic [`ANGLE_W-1:0] rnd_angle;
    logic                rnd_dir;
    int unsigned         seed_val;
    rst_n_i = 1'b0;
    start_i = 1'b0;
    dir_i   = 1'b0;
    angle_i = '0;
    seed_val = $urandom(SEED);
    apply_reset();

    run_move(32'h000A_0000, 1'b0, 1'b0);
    run_move(32'h0007_4000, 1'b1, 1'b0);
    repeat (3) begin
      rnd_angle = $urandom % (30 << 16);
      rnd_dir   = 1'($urandom);
      run_move(rnd_angle, rnd_dir, 1'b0);
    end

    // 45 steps, long enough to cruise
    run_move(32'h001E_0000, 1'b1, 1'b0);
    check_ramp_shape();

    // 0.5 scales to zero steps
    run_move(32'h0000_8000, 1'b0, 1'b0);

    check_largest_angle();
    run_move(32'h000A_0000, 1'b1, 1'b0);
    check_cond(!err_o, "err_o still set after a valid move");

    run_move(32'h000A_0000, 1'b0, 1'b1);
    repeat (4) @(negedge clk_i);
    check_cond(!busy_o && step_cnt == scaled_steps(32'h000A_0000),
               "dropped start produced a move");

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: done_o never came within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: stepper_drive.f
+incdir+logic
logic/stepper_pkg.sv
logic/angle_scaler.sv
logic/ramp_profiler.sv
logic/step_pulse_gen.sv
logic/stepper_drive_top.sv
tests/stepper_drive_tb.sv
